//--- source/router_pkg.sv
/* Stream, beat and route types for the single-ingress router.
   Destination id is taken from bits 3:0 of the first beat of each packet. */
package router_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_EGR_PORTS    = 4;
    localparam int BUF_DEPTH        = 32;
    localparam int ROUTE_FIFO_DEPTH = 4;
    localparam int TABLE_ENTRIES    = 16;

    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
    localparam int RQ_PTR_W  = $clog2(ROUTE_FIFO_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Field types

    typedef logic [31:0] word_t;
    typedef logic [3:0]  dest_id_t;
    typedef logic [1:0]  egr_port_t;

    // Beat buffer indexing
    typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
    // Extra bit so a full buffer can be counted
    typedef logic [BUF_PTR_W:0]   buf_count_t;

    // Route result FIFO indexing
    typedef logic [RQ_PTR_W-1:0] rq_ptr_t;
    typedef logic [RQ_PTR_W:0]   rq_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // Structs

    // Unit of transfer on ingress, buffer and egress
    typedef struct packed {
        word_t data;
        logic  last;
    } beat_t;

    // Lookup outcome for one packet
    typedef struct packed {
        logic      hit;
        egr_port_t port;
    } route_t;

endpackage

//--- source/csr_pkg.sv
/* Register map. Table entries hold valid in bit 2 and the port in bits 1:0.
   Both packet counters are read only and wrap at 2^32. */
package csr_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    ////////////////////////////////////////////////////////////////////////////
    // Addresses

    // Table entries 0 to 15 follow the base
    localparam reg_addr_t ADDR_TABLE_BASE = 8'h00;
    localparam reg_addr_t ADDR_FWD_COUNT  = 8'h20;
    localparam reg_addr_t ADDR_DROP_COUNT = 8'h21;

    // Fields of a table entry
    localparam int ENTRY_VALID_BIT = 2;
    localparam int ENTRY_PORT_LSB  = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Table update toward the lookup stage

    // Strobe is high for one cycle per register write
    typedef struct packed {
        logic                 strobe;
        router_pkg::dest_id_t index;
        router_pkg::route_t   entry;
    } table_wr_t;

endpackage

//--- source/pkt_buffer.sv
/* Circular beat FIFO whose head is readable the cycle after a write.
   Ingress also stalls while the lookup stage has no room for a new route. */
`timescale 1ns/1ps

module pkt_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  router_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              lookup_space,
    output logic              beat_accept,
    output router_pkg::beat_t accepted_beat,
    output router_pkg::beat_t buf_beat,
    output logic              buf_valid,
    input  logic              buf_pop
);

    router_pkg::beat_t      mem [router_pkg::BUF_DEPTH];
    router_pkg::buf_ptr_t   wr_ptr;
    router_pkg::buf_ptr_t   rd_ptr;
    router_pkg::buf_count_t count;
    logic                   running;
    logic                   full;
    logic                   do_pop;

    assign full = (count == router_pkg::buf_count_t'(router_pkg::BUF_DEPTH));

    // Held low until the first cycle after reset release
    assign in_ready = running && !full && lookup_space;

    assign beat_accept   = in_valid && in_ready;
    assign accepted_beat = in_beat;

    assign buf_valid = (count != '0);
    assign buf_beat  = mem[rd_ptr];
    assign do_pop    = buf_pop && buf_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            running <= 1'b1;
            if (beat_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({beat_accept, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat_accept) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule

//--- source/route_lookup.sv
/* Looks up the destination of each packet once, on its first beat.
   Route results queue in a FIFO of ROUTE_FIFO_DEPTH entries, in packet order. */
`timescale 1ns/1ps

module route_lookup (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               beat_accept,
    input  router_pkg::beat_t  accepted_beat,
    input  csr_pkg::table_wr_t table_wr,
    output logic               lookup_space,
    output router_pkg::route_t route_out,
    output logic               route_valid,
    input  logic               route_pop
);

    router_pkg::route_t    route_table [router_pkg::TABLE_ENTRIES];
    router_pkg::dest_id_t  dest_id;
    logic                  first_beat;
    logic                  push_pending;
    router_pkg::route_t    push_route;

    router_pkg::route_t    rq_mem [router_pkg::ROUTE_FIFO_DEPTH];
    router_pkg::rq_ptr_t   rq_wr_ptr;
    router_pkg::rq_ptr_t   rq_rd_ptr;
    router_pkg::rq_count_t rq_count;
    logic                  rq_pop;

    assign dest_id = accepted_beat.data[$bits(router_pkg::dest_id_t)-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Route table

    // All entries start invalid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < router_pkg::TABLE_ENTRIES; i++) begin
                route_table[i] <= '0;
            end
        end else if (table_wr.strobe) begin
            route_table[table_wr.index] <= table_wr.entry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // First beat detection and lookup

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            first_beat   <= 1'b1;
            push_pending <= 1'b0;
            push_route   <= '0;
        end else begin
            push_pending <= beat_accept && first_beat;
            if (beat_accept) begin
                // Beat after a last starts the next packet
                first_beat <= accepted_beat.last;
                if (first_beat) begin
                    push_route <= route_table[dest_id];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Route result FIFO

    assign route_valid = (rq_count != '0);
    assign route_out   = rq_mem[rq_rd_ptr];
    assign rq_pop      = route_pop && route_valid;

    // One slot kept for a lookup still on its way in
    assign lookup_space =
        (rq_count < router_pkg::rq_count_t'(router_pkg::ROUTE_FIFO_DEPTH - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rq_wr_ptr <= '0;
            rq_rd_ptr <= '0;
            rq_count  <= '0;
        end else begin
            if (push_pending) begin
                rq_wr_ptr <= rq_wr_ptr + 1'b1;
            end
            if (rq_pop) begin
                rq_rd_ptr <= rq_rd_ptr + 1'b1;
            end
            case ({push_pending, rq_pop})
                2'b10:   rq_count <= rq_count + 1'b1;
                2'b01:   rq_count <= rq_count - 1'b1;
                default: rq_count <= rq_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_pending) begin
            rq_mem[rq_wr_ptr] <= push_route;
        end
    end

endmodule

//--- source/egress_steer.sv
/* Pairs the head route with the head packet in the beat buffer.
   A hit is sent to one egress port, a miss is drained without any egr_valid. */
`timescale 1ns/1ps

module egress_steer (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  router_pkg::route_t                                route_out,
    input  logic                                              route_valid,
    output logic                                              route_pop,
    input  router_pkg::beat_t                                 buf_beat,
    input  logic                                              buf_valid,
    output logic                                              buf_pop,
    output router_pkg::beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    output logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_valid,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_ready,
    output logic                                              pkt_forwarded,
    output logic                                              pkt_dropped
);

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DISCARD
    } state_t;

    state_t                state;
    state_t                state_next;
    router_pkg::egr_port_t port_q;
    logic                  pkt_start;
    logic                  pkt_end;

    assign pkt_start = (state == IDLE) && route_valid && buf_valid;

    // Last beat leaves the buffer this cycle
    assign pkt_end = buf_pop && buf_beat.last;

    assign route_pop     = pkt_end;
    assign pkt_forwarded = pkt_end && (state == FORWARD);
    assign pkt_dropped   = pkt_end && (state == DISCARD);

    always_comb begin
        state_next = state;
        buf_pop    = 1'b0;
        egr_valid  = '0;
        egr_beat   = '0;
        case (state)
            IDLE: begin
                if (pkt_start) begin
                    state_next = route_out.hit ? FORWARD : DISCARD;
                end
            end
            FORWARD: begin
                egr_valid[port_q] = buf_valid;
                egr_beat[port_q]  = buf_beat;
                buf_pop           = buf_valid && egr_ready[port_q];
                if (buf_pop && buf_beat.last) begin
                    state_next = IDLE;
                end
            end
            DISCARD: begin
                // One beat per cycle, nothing shown on egress
                buf_pop = buf_valid;
                if (buf_pop && buf_beat.last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            port_q <= '0;
        end else begin
            state <= state_next;
            // Port is held for the whole packet
            if (pkt_start) begin
                port_q <= route_out.port;
            end
        end
    end

endmodule

//--- source/router_csr.sv
/* Plain strobe register port with read data on the cycle after reg_rd.
   Table entries read back from a local copy and the counters are read only. */
`timescale 1ns/1ps

module router_csr (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               reg_wr,
    input  logic               reg_rd,
    input  csr_pkg::reg_addr_t reg_addr,
    input  csr_pkg::reg_data_t reg_wdata,
    output csr_pkg::reg_data_t reg_rdata,
    output csr_pkg::table_wr_t table_wr,
    input  logic               pkt_forwarded,
    input  logic               pkt_dropped
);

    localparam int PORT_W = $bits(router_pkg::egr_port_t);

    router_pkg::route_t   shadow [router_pkg::TABLE_ENTRIES];
    csr_pkg::reg_addr_t   table_offset;
    router_pkg::dest_id_t entry_idx;
    logic                 in_table;
    csr_pkg::reg_data_t   fwd_count;
    csr_pkg::reg_data_t   drop_count;
    csr_pkg::reg_data_t   rd_mux;

    assign table_offset = reg_addr - csr_pkg::ADDR_TABLE_BASE;
    assign in_table     = (table_offset < csr_pkg::reg_addr_t'(router_pkg::TABLE_ENTRIES));
    assign entry_idx    = router_pkg::dest_id_t'(table_offset);

    // Table update strobe on the same edge as the register write
    always_comb begin
        table_wr.strobe     = reg_wr && in_table;
        table_wr.index      = entry_idx;
        table_wr.entry.hit  = reg_wdata[csr_pkg::ENTRY_VALID_BIT];
        table_wr.entry.port = reg_wdata[csr_pkg::ENTRY_PORT_LSB +: PORT_W];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux

    always_comb begin
        rd_mux = '0;
        if (in_table) begin
            rd_mux[csr_pkg::ENTRY_VALID_BIT]          = shadow[entry_idx].hit;
            rd_mux[csr_pkg::ENTRY_PORT_LSB +: PORT_W] = shadow[entry_idx].port;
        end else if (reg_addr == csr_pkg::ADDR_FWD_COUNT) begin
            rd_mux = fwd_count;
        end else if (reg_addr == csr_pkg::ADDR_DROP_COUNT) begin
            rd_mux = drop_count;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers and counters

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < router_pkg::TABLE_ENTRIES; i++) begin
                shadow[i] <= '0;
            end
            fwd_count  <= '0;
            drop_count <= '0;
            reg_rdata  <= '0;
        end else begin
            if (table_wr.strobe) begin
                shadow[entry_idx] <= table_wr.entry;
            end
            // Counters wrap at 2^32
            if (pkt_forwarded) begin
                fwd_count <= fwd_count + 1'b1;
            end
            if (pkt_dropped) begin
                drop_count <= drop_count + 1'b1;
            end
            if (reg_rd) begin
                reg_rdata <= rd_mux;
            end
        end
    end

endmodule

//--- source/router_top.sv
/* Single-clock packet router with one ingress stream and four egress ports.
   Packets without a valid table entry are dropped and counted. */
`timescale 1ns/1ps

module router_top (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  router_pkg::beat_t                                 in_beat,
    input  logic                                              in_valid,
    output logic                                              in_ready,
    output router_pkg::beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    output logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_valid,
    input  logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_ready,
    input  logic                                              reg_wr,
    input  logic                                              reg_rd,
    input  csr_pkg::reg_addr_t                                reg_addr,
    input  csr_pkg::reg_data_t                                reg_wdata,
    output csr_pkg::reg_data_t                                reg_rdata
);

    logic               beat_accept;
    router_pkg::beat_t  accepted_beat;
    logic               lookup_space;
    router_pkg::beat_t  buf_beat;
    logic               buf_valid;
    logic               buf_pop;
    router_pkg::route_t route_out;
    logic               route_valid;
    logic               route_pop;
    csr_pkg::table_wr_t table_wr;
    logic               pkt_forwarded;
    logic               pkt_dropped;

    ////////////////////////////////////////////////////////////////////////////
    // Ingress and beat storage

    pkt_buffer i_pkt_buffer (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .in_beat       ( in_beat       ),
        .in_valid      ( in_valid      ),
        .in_ready      ( in_ready      ),
        .lookup_space  ( lookup_space  ),
        .beat_accept   ( beat_accept   ),
        .accepted_beat ( accepted_beat ),
        .buf_beat      ( buf_beat      ),
        .buf_valid     ( buf_valid     ),
        .buf_pop       ( buf_pop       )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Match stage

    route_lookup i_route_lookup (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .beat_accept   ( beat_accept   ),
        .accepted_beat ( accepted_beat ),
        .table_wr      ( table_wr      ),
        .lookup_space  ( lookup_space  ),
        .route_out     ( route_out     ),
        .route_valid   ( route_valid   ),
        .route_pop     ( route_pop     )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Egress

    egress_steer i_egress_steer (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .route_out     ( route_out     ),
        .route_valid   ( route_valid   ),
        .route_pop     ( route_pop     ),
        .buf_beat      ( buf_beat      ),
        .buf_valid     ( buf_valid     ),
        .buf_pop       ( buf_pop       ),
        .egr_beat      ( egr_beat      ),
        .egr_valid     ( egr_valid     ),
        .egr_ready     ( egr_ready     ),
        .pkt_forwarded ( pkt_forwarded ),
        .pkt_dropped   ( pkt_dropped   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Registers

    router_csr i_router_csr (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .reg_wr        ( reg_wr        ),
        .reg_rd        ( reg_rd        ),
        .reg_addr      ( reg_addr      ),
        .reg_wdata     ( reg_wdata     ),
        .reg_rdata     ( reg_rdata     ),
        .table_wr      ( table_wr      ),
        .pkt_forwarded ( pkt_forwarded ),
        .pkt_dropped   ( pkt_dropped   )
    );

endmodule

//--- sim/router_properties.sv
/* Checks bound into egress_steer, sampled on the rising clock edge.
   Stall stability is checked on each egress port separately. */
`timescale 1ns/1ps

module router_properties (
    input logic                                              clk,
    input logic                                              arst_n,
    input logic                                              buf_valid,
    input logic                                              buf_pop,
    input router_pkg::beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat,
    input logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_valid,
    input logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_ready
);

    // Only one port carries the current packet
    one_port_valid: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(egr_valid))
        else $error("more than one egress port valid at once");

    pop_needs_data: assert property (@(posedge clk) disable iff (!arst_n)
        buf_pop |-> buf_valid)
        else $error("beat buffer popped while empty");

    for (genvar p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin : g_port
        hold_when_stalled: assert property (@(posedge clk) disable iff (!arst_n)
            (egr_valid[p] && !egr_ready[p]) |=> (egr_valid[p] && $stable(egr_beat[p])))
            else $error("egress port %0d beat changed while stalled", p);
    end

endmodule

//--- sim/router_tb.sv
/* Directed testbench for router_top with a scoreboard of expected beats per port.
   Table entries whose index is 3 mod 4 stay invalid, so those destinations drop. */
`timescale 1ns/1ps

module router_tb;

    localparam int WAIT_LIMIT  = 1000;
    localparam int DRAIN_LIMIT = 400;
    localparam int NUM_MIXED   = 20;

    logic                                              clk;
    logic                                              arst_n;
    router_pkg::beat_t                                 in_beat;
    logic                                              in_valid;
    logic                                              in_ready;
    router_pkg::beat_t [router_pkg::NUM_EGR_PORTS-1:0] egr_beat;
    logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_valid;
    logic [router_pkg::NUM_EGR_PORTS-1:0]              egr_ready;
    logic                                              reg_wr;
    logic                                              reg_rd;
    csr_pkg::reg_addr_t                                reg_addr;
    csr_pkg::reg_data_t                                reg_wdata;
    csr_pkg::reg_data_t                                reg_rdata;

    int                 seed;
    int                 errors;
    int                 checks;
    int                 mon_errors;
    int                 mon_checks;
    int                 fwd_exp;
    int                 drop_exp;
    logic               timed_out;
    logic               traffic_done;
    router_pkg::route_t model_table [router_pkg::TABLE_ENTRIES];
    router_pkg::beat_t  exp_q [router_pkg::NUM_EGR_PORTS][$];

    router_top i_dut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .in_beat   ( in_beat   ),
        .in_valid  ( in_valid  ),
        .in_ready  ( in_ready  ),
        .egr_beat  ( egr_beat  ),
        .egr_valid ( egr_valid ),
        .egr_ready ( egr_ready ),
        .reg_wr    ( reg_wr    ),
        .reg_rd    ( reg_rd    ),
        .reg_addr  ( reg_addr  ),
        .reg_wdata ( reg_wdata ),
        .reg_rdata ( reg_rdata )
    );

    bind egress_steer router_properties i_properties (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .buf_valid ( buf_valid ),
        .buf_pop   ( buf_pop   ),
        .egr_beat  ( egr_beat  ),
        .egr_valid ( egr_valid ),
        .egr_ready ( egr_ready )
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Egress scoreboard

    always @(posedge clk) begin : egress_monitor
        router_pkg::beat_t expected;
        if (arst_n) begin
            for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
                if (egr_valid[p] && exp_q[p].size() == 0) begin
                    mon_errors++;
                    $display("%0t: port %0d went valid with no packet routed to it", $time, p);
                end else if (egr_valid[p] && egr_ready[p]) begin
                    expected = exp_q[p].pop_front();
                    mon_checks++;
                    if (egr_beat[p] !== expected) begin
                        mon_errors++;
                        $display("[ERROR] %0t egr_beat[%0d] got %h expected %h",
                                 $time, p, egr_beat[p], expected);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers entered and left just after a falling edge

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_register(input csr_pkg::reg_addr_t addr, input csr_pkg::reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    // Read data is registered on the edge that samples reg_rd
    task automatic read_register(input csr_pkg::reg_addr_t addr, output csr_pkg::reg_data_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int p = 0; p < router_pkg::NUM_EGR_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic send_packet(input router_pkg::dest_id_t dest, input int len,
                               input router_pkg::word_t base);
        router_pkg::beat_t beat;
        int                tries;
        if (model_table[dest].hit) begin
            fwd_exp++;
        end else begin
            drop_exp++;
        end
        for (int k = 0; k < len; k++) begin
            // Low nibble of the first beat is the destination id
            beat.data = {base[31:16], 12'(k), dest};
            beat.last = (k == len - 1);
            if (model_table[dest].hit) begin
                exp_q[model_table[dest].port].push_back(beat);
            end
        end
        for (int k = 0; k < len; k++) begin
            beat.data = {base[31:16], 12'(k), dest};
            beat.last = (k == len - 1);
            in_beat   = beat;
            in_valid  = 1'b1;
            tries     = 0;
            while (!in_ready && tries < WAIT_LIMIT) begin
                @(negedge clk);
                tries++;
            end
            if (!in_ready) begin
                errors++;
                timed_out = 1'b1;
                in_valid  = 1'b0;
                $display("%0t: ingress never became ready for beat %0d", $time, k);
                return;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // Polls both counters until they and the scoreboard settle
    task automatic wait_drain();
        csr_pkg::reg_data_t fwd;
        csr_pkg::reg_data_t drop;
        int                 tries;
        logic               settled;
        tries   = 0;
        settled = 1'b0;
        while (!settled && tries < DRAIN_LIMIT) begin
            read_register(csr_pkg::ADDR_FWD_COUNT, fwd);
            read_register(csr_pkg::ADDR_DROP_COUNT, drop);
            settled = (fwd == 32'(fwd_exp)) && (drop == 32'(drop_exp)) && queues_empty();
            tries++;
        end
        if (!settled) begin
            errors++;
            timed_out = 1'b1;
            $display("%0t: traffic did not drain within %0d register polls", $time, DRAIN_LIMIT);
        end
        check_value("fwd_count", fwd, 32'(fwd_exp));
        check_value("drop_count", drop, 32'(drop_exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic register_readback();
        csr_pkg::reg_data_t data;
        int                 rnd;
        for (int i = 0; i < router_pkg::TABLE_ENTRIES; i++) begin
            rnd = $random(seed);
            model_table[i].hit  = (i % 4 != 3);
            model_table[i].port = 2'(i / 4);
            // Upper bits are junk and must not read back
            write_register(8'(i), {rnd[31:3], model_table[i].hit, model_table[i].port});
        end
        for (int i = 0; i < router_pkg::TABLE_ENTRIES; i++) begin
            read_register(8'(i), data);
            check_value($sformatf("table[%0d]", i), data,
                        {29'b0, model_table[i].hit, model_table[i].port});
        end
        read_register(csr_pkg::ADDR_FWD_COUNT, data);
        check_value("fwd_count", data, 32'h0);
        read_register(csr_pkg::ADDR_DROP_COUNT, data);
        check_value("drop_count", data, 32'h0);
    endtask

    task automatic forward_packet();
        send_packet(4'd5, 4, 32'hA5A5_0000);
        send_packet(4'd10, 1, 32'h1234_0000);
        wait_drain();
    endtask

    task automatic drop_on_miss();
        send_packet(4'd7, 3, 32'hDEAD_0000);
        send_packet(4'd15, 1, 32'hBEEF_0000);
        wait_drain();
    endtask

    task automatic backpressure_stall();
        logic stalled;
        int   tries;
        stalled   = 1'b0;
        tries     = 0;
        egr_ready = 4'b1110;
        fork
            send_packet(4'd0, 40, 32'h5A5A_0000);
            begin
                while (!stalled && tries < WAIT_LIMIT) begin
                    @(negedge clk);
                    tries++;
                    stalled = in_valid && !in_ready;
                end
                if (!stalled) begin
                    errors++;
                    $display("%0t: in_ready never fell while port 0 was held off", $time);
                end
                repeat (5) @(negedge clk);
                egr_ready = 4'b1111;
            end
        join
        wait_drain();
    endtask

    task automatic mixed_traffic();
        int                   rnd;
        int                   pkt_len  [NUM_MIXED];
        router_pkg::dest_id_t pkt_dest [NUM_MIXED];
        router_pkg::word_t    pkt_base [NUM_MIXED];
        for (int i = 0; i < NUM_MIXED; i++) begin
            rnd         = $random(seed);
            pkt_len[i]  = int'($unsigned(rnd) % 12) + 1;
            pkt_dest[i] = rnd[11:8];
            pkt_base[i] = $random(seed);
        end
        traffic_done = 1'b0;
        fork
            begin
                for (int i = 0; i < NUM_MIXED && !timed_out; i++) begin
                    send_packet(pkt_dest[i], pkt_len[i], pkt_base[i]);
                end
                traffic_done = 1'b1;
            end
            begin
                while (!traffic_done) begin
                    @(negedge clk);
                    rnd       = $random(seed);
                    egr_ready = rnd[3:0];
                end
            end
        join
        egr_ready = 4'b1111;
        wait_drain();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_beat      = '0;
        in_valid     = 1'b0;
        egr_ready    = '0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        seed         = 32'h8e02;
        errors       = 0;
        checks       = 0;
        mon_errors   = 0;
        mon_checks   = 0;
        fwd_exp      = 0;
        drop_exp     = 0;
        timed_out    = 1'b0;
        traffic_done = 1'b0;
        for (int i = 0; i < router_pkg::TABLE_ENTRIES; i++) begin
            model_table[i] = '0;
        end
        repeat (10) @(negedge clk);
        check_value("in_ready", 32'(in_ready), 32'h0);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("egr_valid", 32'(egr_valid), 32'h0);

        register_readback();
        egr_ready = 4'b1111;
        if (!timed_out) begin
            forward_packet();
        end
        if (!timed_out) begin
            drop_on_miss();
        end
        if (!timed_out) begin
            backpressure_stall();
        end
        if (!timed_out) begin
            mixed_traffic();
        end

        $display("checks: %0d  errors: %0d", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
source/router_pkg.sv
source/csr_pkg.sv
source/pkt_buffer.sv
source/route_lookup.sv
source/egress_steer.sv
source/router_csr.sv
source/router_top.sv
sim/router_properties.sv
sim/router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the router testbench with Verilator, runs it and scans the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module router_tb -f src.f \
    && ./obj_dir/Vrouter_tb 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

echo "simulation passed"
exit 0
